/* verilog/ticker_consts.svh */
`ifndef TICKER_CONSTS_SVH
`define TICKER_CONSTS_SVH

// ##########################################################
// Bus widths
// ##########################################################
`define TICK_DATA_W 32 // APB data and timer register width
`define TICK_ADDR_W 12

// ##########################################################
// Channel map
// ##########################################################
`define TICK_NUM_CH 4 // 1 to 15
`define TICK_CH_LSB 4 // Channel field is paddr[7:4]
`define TICK_CH_W 4
`define TICK_REG_LSB 2 // Register field is paddr[3:2]
`define TICK_GLOBAL_SLOT 15 // Read-only pending vector

`endif

/* verilog/ticker_pkg.sv */
`default_nettype none

package ticker_pkg;

    // ##########################################################
    // Register map inside one channel
    // ##########################################################
    typedef enum logic [1:0] {
        REG_CTRL    = 2'd0, // 0x0 en, irq en, auto-reload
        REG_COMPARE = 2'd1, // 0x4
        REG_COUNT   = 2'd2, // 0x8
        REG_STATUS  = 2'd3  // 0xC match flag, write 1 to clear
    } tick_reg_e;

    // ##########################################################
    // APB transfer phase
    // ##########################################################
    typedef enum logic [1:0] {
        PH_IDLE   = 2'd0,
        PH_SETUP  = 2'd1,
        PH_ACCESS = 2'd2
    } apb_phase_e;

endpackage

`default_nettype wire

/* verilog/ticker_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ticker_consts.svh"

module ticker_decoder import ticker_pkg::*; (
    input  wire                      clk_bus_i,
    input  wire                      arst_n_i,
    input  wire                      psel_i,
    input  wire                      penable_i,
    input  wire                      pwrite_i,
    input  wire [`TICK_ADDR_W-1:0]   paddr_i,
    input  wire [`TICK_DATA_W-1:0]   pwdata_i,
    output logic [`TICK_NUM_CH-1:0]  wr_en_o,
    output tick_reg_e                reg_sel_o,
    output logic [`TICK_DATA_W-1:0]  wdata_o,
    output logic [`TICK_CH_W-1:0]    ch_idx_o,
    output logic                     global_sel_o,
    output logic                     pready_o,
    output logic                     pslverr_o
);

    localparam int unsigned NUM_CH = `TICK_NUM_CH;
    localparam int unsigned CH_W = `TICK_CH_W;
    localparam logic [CH_W-1:0] GLOBAL_SLOT = `TICK_GLOBAL_SLOT;

    apb_phase_e phase_q;
    apb_phase_e phase_d;
    logic [CH_W-1:0] ch_field;
    logic [1:0] reg_field;
    logic access;
    logic ch_mapped;
    logic err;
    logic wr_ok;

    // ##########################################################
    // Phase tracking
    // ##########################################################
    // phase_q holds the phase of the previous cycle, so only the first
    // cycle with penable high after a setup counts as the access cycle
    always_comb begin
        phase_d = PH_IDLE;
        if (psel_i && !penable_i) begin
            phase_d = PH_SETUP;
        end else if (psel_i && penable_i) begin
            phase_d = PH_ACCESS;
        end
    end

    always_ff @(posedge clk_bus_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_q <= PH_IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    assign access = psel_i && penable_i && (phase_q == PH_SETUP);

    // ##########################################################
    // Address decode
    // ##########################################################
    assign ch_field = paddr_i[`TICK_CH_LSB +: CH_W];
    assign reg_field = paddr_i[`TICK_REG_LSB +: 2];

    assign ch_idx_o = ch_field;
    assign reg_sel_o = tick_reg_e'(reg_field);
    assign wdata_o = pwdata_i;
    assign global_sel_o = (ch_field == GLOBAL_SLOT);
    assign ch_mapped = (ch_field < NUM_CH);

    // Unmapped channel, or a write to the read-only slot
    assign err = (!ch_mapped && !global_sel_o) || (global_sel_o && pwrite_i);

    assign pready_o = access; // Zero wait states
    assign pslverr_o = access && err;
    assign wr_ok = access && pwrite_i && ch_mapped;

    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            wr_en_o[i] = wr_ok && (ch_field == CH_W'(i));
        end
    end

endmodule

`default_nettype wire

/* verilog/ticker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ticker_consts.svh"

module ticker import ticker_pkg::*; (
    input  wire                      clk_bus_i,
    input  wire                      arst_n_i,
    input  wire                      wr_en_i,
    input  wire tick_reg_e           reg_sel_i,
    input  wire [`TICK_DATA_W-1:0]   wdata_i,
    output logic [`TICK_DATA_W-1:0]  rdata_o,
    output logic                     irq_o
);

    localparam int unsigned DATA_W = `TICK_DATA_W;

    logic en_q;
    logic ie_q;
    logic reload_q;
    logic flag_q;
    logic [DATA_W-1:0] compare_q;
    logic [DATA_W-1:0] count_q;

    logic wr_ctrl;
    logic wr_compare;
    logic wr_count;
    logic wr_status;
    logic match;

    assign wr_ctrl = wr_en_i && (reg_sel_i == REG_CTRL);
    assign wr_compare = wr_en_i && (reg_sel_i == REG_COMPARE);
    assign wr_count = wr_en_i && (reg_sel_i == REG_COUNT);
    assign wr_status = wr_en_i && (reg_sel_i == REG_STATUS);

    assign match = en_q && (count_q == compare_q);

    // ##########################################################
    // Control and compare
    // ##########################################################
    always_ff @(posedge clk_bus_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q <= 1'b0;
            ie_q <= 1'b0;
            reload_q <= 1'b0;
        end else if (wr_ctrl) begin
            en_q <= wdata_i[0];
            ie_q <= wdata_i[1];
            reload_q <= wdata_i[2];
        end else if (match && !reload_q) begin
            en_q <= 1'b0; // One-shot stops itself
        end
    end

    always_ff @(posedge clk_bus_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            compare_q <= '0;
        end else if (wr_compare) begin
            compare_q <= wdata_i;
        end
    end

    // ##########################################################
    // Counter
    // ##########################################################
    always_ff @(posedge clk_bus_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (wr_count) begin
            count_q <= wdata_i;
        end else if (match) begin
            if (reload_q) begin
                count_q <= '0;
            end // One-shot holds at compare
        end else if (en_q) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Hardware match beats a software clear on the same edge
    always_ff @(posedge clk_bus_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            flag_q <= 1'b0;
        end else if (match) begin
            flag_q <= 1'b1;
        end else if (wr_status && wdata_i[0]) begin
            flag_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_bus_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_o <= 1'b0;
        end else begin
            irq_o <= flag_q && ie_q;
        end
    end

    // ##########################################################
    // Read-back
    // ##########################################################
    always_comb begin
        rdata_o = '0;
        case (reg_sel_i)
            REG_CTRL: rdata_o[2:0] = {reload_q, ie_q, en_q};
            REG_COMPARE: rdata_o = compare_q;
            REG_COUNT: rdata_o = count_q;
            REG_STATUS: rdata_o[0] = flag_q;
            default: rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/ticker_rdmux.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ticker_consts.svh"

module ticker_rdmux (
    input  wire                                      clk_bus_i,
    input  wire                                      arst_n_i,
    input  wire [`TICK_CH_W-1:0]                     ch_idx_i,
    input  wire                                      global_sel_i,
    input  wire [`TICK_NUM_CH-1:0][`TICK_DATA_W-1:0] ch_rdata_i,
    input  wire [`TICK_NUM_CH-1:0]                   ch_irq_i,
    output logic [`TICK_DATA_W-1:0]                  prdata_o,
    output logic                                     irq_o
);

    localparam int unsigned NUM_CH = `TICK_NUM_CH;
    localparam int unsigned CH_W = `TICK_CH_W;
    localparam int unsigned DATA_W = `TICK_DATA_W;

    logic any_irq;

    // ##########################################################
    // Read data select
    // ##########################################################
    // Unmapped channels fall through to zero
    always_comb begin
        prdata_o = '0;
        if (global_sel_i) begin
            prdata_o = DATA_W'(ch_irq_i); // Pending vector, zero-extended
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (ch_idx_i == CH_W'(i)) begin
                    prdata_o = ch_rdata_i[i];
                end
            end
        end
    end

    // ##########################################################
    // Interrupt combine
    // ##########################################################
    assign any_irq = |ch_irq_i;

    always_ff @(posedge clk_bus_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_o <= 1'b0;
        end else begin
            irq_o <= any_irq;
        end
    end

endmodule

`default_nettype wire

/* verilog/ticker_subsys.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ticker_consts.svh"

module ticker_subsys import ticker_pkg::*; (
    input  wire                      clk_bus_i,
    input  wire                      arst_n_i,
    input  wire                      psel_i,
    input  wire                      penable_i,
    input  wire                      pwrite_i,
    input  wire [`TICK_ADDR_W-1:0]   paddr_i,
    input  wire [`TICK_DATA_W-1:0]   pwdata_i,
    output wire [`TICK_DATA_W-1:0]   prdata_o,
    output wire                      pready_o,
    output wire                      pslverr_o,
    output wire                      irq_o
);

    localparam int unsigned NUM_CH = `TICK_NUM_CH;
    localparam int unsigned DATA_W = `TICK_DATA_W;

    wire [NUM_CH-1:0] wr_en;
    tick_reg_e reg_sel;
    wire [DATA_W-1:0] wdata;
    wire [`TICK_CH_W-1:0] ch_idx;
    wire global_sel;
    wire [NUM_CH-1:0][DATA_W-1:0] ch_rdata;
    wire [NUM_CH-1:0] ch_irq;

    ticker_decoder i_decoder (
        .clk_bus_i    (clk_bus_i),
        .arst_n_i     (arst_n_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .wr_en_o      (wr_en),
        .reg_sel_o    (reg_sel),
        .wdata_o      (wdata),
        .ch_idx_o     (ch_idx),
        .global_sel_o (global_sel),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o)
    );

    generate
        for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
            ticker i_ticker (
                .clk_bus_i (clk_bus_i),
                .arst_n_i  (arst_n_i),
                .wr_en_i   (wr_en[i]),
                .reg_sel_i (reg_sel),
                .wdata_i   (wdata),
                .rdata_o   (ch_rdata[i]),
                .irq_o     (ch_irq[i])
            );
        end
    endgenerate

    ticker_rdmux i_rdmux (
        .clk_bus_i    (clk_bus_i),
        .arst_n_i     (arst_n_i),
        .ch_idx_i     (ch_idx),
        .global_sel_i (global_sel),
        .ch_rdata_i   (ch_rdata),
        .ch_irq_i     (ch_irq),
        .prdata_o     (prdata_o),
        .irq_o        (irq_o)
    );

endmodule

`default_nettype wire

/* dv/tb_ticker_subsys.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ticker_consts.svh"

module tb_ticker_subsys import ticker_pkg::*; ();

    localparam int NUM_CH = `TICK_NUM_CH;
    localparam int DATA_W = `TICK_DATA_W;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS = 6;
    localparam int MAX_CMP = 40; // Largest compare used by the timed tests
    localparam int XFER_CYCLES = 3;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_CMP * XFER_CYCLES + 2000;

    logic clk_bus;
    logic arst_n;
    logic psel;
    logic penable;
    logic pwrite;
    logic [`TICK_ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic pready;
    logic pslverr;
    logic irq;

    logic prev_setup;
    logic [DATA_W-1:0] ref_ctrl [NUM_CH];
    logic [DATA_W-1:0] ref_cmp [NUM_CH];
    string test_name;
    int errors;
    int test_errors;
    int checks;
    int tests_run;

    ticker_subsys i_dut (
        .clk_bus_i (clk_bus),
        .arst_n_i  (arst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .irq_o     (irq)
    );

    initial begin
        clk_bus = 1'b0;
        forever #(CLK_PERIOD / 2) clk_bus = ~clk_bus;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    // ##########################################################
    // APB protocol check
    // ##########################################################
    always @(posedge clk_bus or negedge arst_n) begin
        if (!arst_n) begin
            prev_setup <= 1'b0;
        end else begin
            prev_setup <= psel && !penable; // Previous cycle was a setup
        end
    end

    a_pready_access: assert property (@(negedge clk_bus) disable iff (!arst_n)
        pready == (psel && penable && prev_setup)) else begin
        $display("pready_o does not follow the access cycle at time %0t", $time);
        errors++;
        test_errors++;
    end

    // ##########################################################
    // Checks and reporting
    // ##########################################################
    task automatic check_eq(input string what, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] got);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s %s: expected 0x%08h, got 0x%08h", test_name, what, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_le(input string what, input logic [DATA_W-1:0] limit,
                            input logic [DATA_W-1:0] got);
        checks++;
        assert (got <= limit) else begin
            $display("[FAIL] %s %s: expected <= 0x%08h, got 0x%08h", test_name, what, limit, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("Error in test %s: %s", test_name, msg);
        errors++;
        test_errors++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %-12s ok", test_name);
        end else begin
            $display("test %-12s %0d error(s)", test_name, test_errors);
        end
    endtask

    // ##########################################################
    // APB driver
    // ##########################################################
    function automatic logic [`TICK_ADDR_W-1:0] reg_addr(input int ch, input tick_reg_e sel);
        logic [`TICK_ADDR_W-1:0] a;
        a = '0;
        a[`TICK_CH_LSB +: `TICK_CH_W] = ch[`TICK_CH_W-1:0];
        a[`TICK_REG_LSB +: 2] = sel;
        return a;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [`TICK_ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat,
                            output logic err);
        int waits;
        waits = 0;
        @(posedge clk_bus);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= wdat;
        @(posedge clk_bus);
        penable <= 1'b1;
        @(negedge clk_bus);
        while (!pready && waits < 4) begin
            @(negedge clk_bus);
            waits++;
        end
        if (!pready) begin
            report_problem("pready_o never rose during the access phase");
        end
        rdat = prdata;
        err = pslverr;
        @(posedge clk_bus);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input int ch, input tick_reg_e sel, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused;
        logic err;
        apb_xfer(1'b1, reg_addr(ch, sel), data, unused, err);
        check_eq($sformatf("ch%0d write pslverr", ch), 0, err);
    endtask

    task automatic read_reg(input int ch, input tick_reg_e sel, output logic [DATA_W-1:0] data);
        logic err;
        apb_xfer(1'b0, reg_addr(ch, sel), '0, data, err);
        check_eq($sformatf("ch%0d read pslverr", ch), 0, err);
    endtask

    task automatic poll_flag(input int ch);
        logic [DATA_W-1:0] st;
        int polls;
        polls = 0;
        st = '0;
        while (!st[0] && polls < MAX_CMP) begin
            read_reg(ch, REG_STATUS, st);
            polls++;
        end
        if (!st[0]) begin
            report_problem($sformatf("ch%0d match flag never set", ch));
        end
    endtask

    task automatic wait_irq(input logic level, output logic seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < 6 && !seen; n++) begin
            @(negedge clk_bus);
            seen = (irq == level);
        end
    endtask

    task automatic check_refs();
        logic [DATA_W-1:0] rd;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            read_reg(ch, REG_CTRL, rd);
            check_eq($sformatf("ch%0d ctrl", ch), ref_ctrl[ch], rd);
            read_reg(ch, REG_COMPARE, rd);
            check_eq($sformatf("ch%0d compare", ch), ref_cmp[ch], rd);
        end
    endtask

    // ##########################################################
    // Test sequence
    // ##########################################################
    initial begin
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] cmp;
        logic [DATA_W-1:0] ctrl;
        logic err;
        logic seen;
        void'($urandom(32'h586a));
        errors = 0;
        checks = 0;
        tests_run = 0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        arst_n = 1'b0;
        repeat (16) @(posedge clk_bus);
        arst_n <= 1'b1;

        start_test("readback");
        for (int ch = 0; ch < NUM_CH; ch++) begin
            ref_ctrl[ch] = $urandom & 32'h6; // Enable stays clear
            ref_cmp[ch] = $urandom;
            write_reg(ch, REG_CTRL, ref_ctrl[ch]);
            write_reg(ch, REG_COMPARE, ref_cmp[ch]);
        end
        check_refs();
        end_test();

        start_test("one_shot");
        cmp = 8 + ($urandom % (MAX_CMP - 8));
        write_reg(0, REG_COUNT, 0);
        write_reg(0, REG_COMPARE, cmp);
        write_reg(0, REG_CTRL, 32'h1); // Enable last so counting starts here
        poll_flag(0);
        read_reg(0, REG_COUNT, rd);
        check_eq("count at match", cmp, rd);
        read_reg(0, REG_CTRL, rd);
        check_eq("ctrl after match", 0, rd);
        ref_ctrl[0] = 0;
        ref_cmp[0] = cmp;
        end_test();

        start_test("auto_reload");
        cmp = 8 + ($urandom % (MAX_CMP - 8));
        write_reg(1, REG_COUNT, 0);
        write_reg(1, REG_COMPARE, cmp);
        write_reg(1, REG_STATUS, 32'h1);
        write_reg(1, REG_CTRL, 32'h5);
        poll_flag(1);
        read_reg(1, REG_COUNT, rd);
        check_le("count after reload", cmp, rd);
        read_reg(1, REG_CTRL, rd);
        check_eq("ctrl still enabled", 32'h5, rd);
        write_reg(1, REG_CTRL, 32'h4);
        write_reg(1, REG_STATUS, 32'h1);
        ref_ctrl[1] = 32'h4;
        ref_cmp[1] = cmp;
        end_test();

        start_test("irq_clear");
        @(negedge clk_bus);
        check_eq("irq_o idle", 0, irq);
        cmp = 8 + ($urandom % (MAX_CMP - 8));
        write_reg(3, REG_COUNT, 0);
        write_reg(3, REG_COMPARE, cmp);
        write_reg(3, REG_CTRL, 32'h1); // No interrupt enable
        poll_flag(3);
        wait_irq(1'b1, seen);
        check_eq("irq_o without enable", 0, seen);
        apb_xfer(1'b0, reg_addr(`TICK_GLOBAL_SLOT, REG_CTRL), '0, rd, err);
        check_eq("global pslverr", 0, err);
        check_eq("global vector", 0, rd);
        write_reg(2, REG_COUNT, 0);
        write_reg(2, REG_COMPARE, cmp);
        write_reg(2, REG_CTRL, 32'h3);
        poll_flag(2);
        wait_irq(1'b1, seen);
        check_eq("irq_o raised", 1, seen);
        apb_xfer(1'b0, reg_addr(`TICK_GLOBAL_SLOT, REG_CTRL), '0, rd, err);
        check_eq("global vector ch2", 32'h4, rd);
        read_reg(2, REG_CTRL, rd);
        check_eq("ch2 ctrl disabled", 32'h2, rd);
        write_reg(2, REG_STATUS, 32'h1);
        read_reg(2, REG_STATUS, rd);
        check_eq("status cleared", 0, rd);
        wait_irq(1'b0, seen);
        check_eq("irq_o fell", 1, seen);
        apb_xfer(1'b0, reg_addr(`TICK_GLOBAL_SLOT, REG_CTRL), '0, rd, err);
        check_eq("global vector cleared", 0, rd);
        ref_ctrl[2] = 32'h2;
        ref_cmp[2] = cmp;
        ref_ctrl[3] = 0;
        ref_cmp[3] = cmp;
        end_test();

        start_test("isolation");
        for (int t = 0; t < NUM_CH; t++) begin
            ctrl = $urandom & 32'h6;
            cmp = $urandom;
            write_reg(t, REG_COMPARE, cmp);
            write_reg(t, REG_CTRL, ctrl);
            ref_ctrl[t] = ctrl;
            ref_cmp[t] = cmp;
            check_refs();
        end
        end_test();

        start_test("decode_err");
        if (NUM_CH < `TICK_GLOBAL_SLOT) begin
            apb_xfer(1'b0, reg_addr(NUM_CH, REG_COMPARE), '0, rd, err);
            check_eq("unmapped read pslverr", 1, err);
            check_eq("unmapped read data", 0, rd);
            apb_xfer(1'b1, reg_addr(NUM_CH, REG_COMPARE), $urandom, rd, err);
            check_eq("unmapped write pslverr", 1, err);
        end
        apb_xfer(1'b1, reg_addr(`TICK_GLOBAL_SLOT, REG_CTRL), 32'hffff_ffff, rd, err);
        check_eq("global write pslverr", 1, err);
        check_refs();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/ticker_pkg.sv
verilog/ticker_decoder.sv
verilog/ticker.sv
verilog/ticker_rdmux.sv
verilog/ticker_subsys.sv
dv/tb_ticker_subsys.sv
